//--- verilog/riscv_pkg.sv
/*
  RISC-V architectural definitions shared by the controller blocks.
  Covers privilege levels, trap cause codes and the interrupt line group.
*/

package riscv_pkg;

  // data and address word (pc, instruction, mtval, lsu address)
  typedef logic [31:0] word_t;

  // compressed instruction half
  typedef logic [15:0] half_t;

  // index of a fast interrupt line
  typedef logic [3:0] fast_id_t;

  // privilege levels, only M and U are implemented
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  ////////////////////////////////////////////////////////////////////
  // trap causes, bit 5 flags an interrupt
  ////////////////////////////////////////////////////////////////////

  typedef enum logic [5:0] {
    EXC_CAUSE_INSTR_ACCESS_FAULT = 6'h01,
    EXC_CAUSE_ILLEGAL_INSN       = 6'h02,
    EXC_CAUSE_BREAKPOINT         = 6'h03,
    EXC_CAUSE_LOAD_ACCESS_FAULT  = 6'h05,
    EXC_CAUSE_STORE_ACCESS_FAULT = 6'h07,
    EXC_CAUSE_ECALL_UMODE        = 6'h08,
    EXC_CAUSE_ECALL_MMODE        = 6'h0B,
    EXC_CAUSE_IRQ_SOFTWARE_M     = 6'h23,
    EXC_CAUSE_IRQ_TIMER_M        = 6'h27,
    EXC_CAUSE_IRQ_EXTERNAL_M     = 6'h2B,
    // fast line n maps to 16+n, so the range is 6'h30 up to 6'h3E
    EXC_CAUSE_IRQ_FAST_0         = 6'h30,
    EXC_CAUSE_IRQ_FAST_14        = 6'h3E,
    EXC_CAUSE_IRQ_NM             = 6'h3F
  } exc_cause_e;

  // interrupt lines as seen by the core, already masked by mie
  typedef struct packed {
    logic        irq_software;
    logic        irq_timer;
    logic        irq_external;
    logic [14:0] irq_fast;
  } irqs_t;

endpackage

//--- verilog/ctrl_pkg.sv
/*
  Controller microarchitecture definitions.
  PC selectors, FSM states and the structs passed between the decision blocks.
*/

package ctrl_pkg;

  import riscv_pkg::*;

  // fetch address selector, only meaningful with pc_set
  typedef enum logic [1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET
  } pc_sel_e;

  // main controller FSM states
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_e;

  ////////////////////////////////////////////////////////////////////
  // structs
  ////////////////////////////////////////////////////////////////////

  // raw decoder flags, not yet qualified by instr_valid
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic wfi;
    logic ebrk;
    logic csr_flush;
  } dec_flags_t;

  // instruction in the IF-ID register
  typedef struct packed {
    word_t instr;
    half_t instr_c;
    logic  is_compressed;
    logic  fetch_err;
    logic  fetch_err_plus2;
    word_t pc;
  } instr_info_t;

  // qualified requests from the exception block to the FSM
  typedef struct packed {
    logic special;
    logic exc_pending;
    logic mret;
    logic wfi;
    logic csr_flush;
  } flush_req_t;

endpackage

//--- verilog/exc_prio.sv
/*
  Synchronous exception handling for the controller.
  Qualifies decoder flags, registers the requests and picks the winning cause and mtval.
*/

`timescale 1ns/1ps

module exc_prio
  import riscv_pkg::*;
  import ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  input  logic        instr_valid_i,
  input  dec_flags_t  dec_i,
  input  instr_info_t instr_i,

  input  priv_lvl_e   priv_mode_i,
  input  logic        csr_mstatus_tw_i,

  input  logic        load_err_i,
  input  logic        store_err_i,
  input  word_t       lsu_addr_last_i,

  input  logic        in_flush_i,

  output flush_req_t  req_o,
  output exc_cause_e  exc_cause_o,
  output word_t       mtval_o
);

  logic ecall, mret, wfi, ebrk, csr_flush, fetch_err;
  logic illegal_umode;
  logic illegal_d, illegal_q;
  logic exc_req_d, exc_req_q;
  logic load_err_d, load_err_q;
  logic store_err_d, store_err_q;

  ////////////////////////////////////////////////////////////////////
  // qualification
  ////////////////////////////////////////////////////////////////////

  // decoder flags ignore instr_valid
  assign ecall     = dec_i.ecall     & instr_valid_i;
  assign mret      = dec_i.mret      & instr_valid_i;
  assign wfi       = dec_i.wfi       & instr_valid_i;
  assign ebrk      = dec_i.ebrk      & instr_valid_i;
  assign csr_flush = dec_i.csr_flush & instr_valid_i;
  assign fetch_err = instr_i.fetch_err & instr_valid_i;

  // mret needs M-mode, tw traps wfi outside M-mode
  assign illegal_umode = (priv_mode_i != PRIV_LVL_M) & (mret | (csr_mstatus_tw_i & wfi));

  // flops break the path from illegal csr decode to pc_set
  // in flush the request has been handled, so drop it
  assign illegal_d   = ((dec_i.illegal & instr_valid_i) | illegal_umode) & ~in_flush_i;
  assign exc_req_d   = (ecall | ebrk | illegal_d | fetch_err) & ~in_flush_i;
  assign load_err_d  = load_err_i  & ~in_flush_i;
  assign store_err_d = store_err_i & ~in_flush_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q   <= 1'b0;
      exc_req_q   <= 1'b0;
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      illegal_q   <= illegal_d;
      exc_req_q   <= exc_req_d;
      load_err_q  <= load_err_d;
      store_err_q <= store_err_d;
    end
  end

  // lsu faults arrive without a valid instruction in ID
  assign req_o.special     = mret | wfi | csr_flush | exc_req_d | load_err_i | store_err_i;
  assign req_o.exc_pending = exc_req_q | load_err_q | store_err_q;
  assign req_o.mret        = mret;
  assign req_o.wfi         = wfi;
  assign req_o.csr_flush   = csr_flush;

  ////////////////////////////////////////////////////////////////////
  // priority select
  ////////////////////////////////////////////////////////////////////

  // instruction is retained in ID through FLUSH, its flags are still live
  always_comb begin
    exc_cause_o = EXC_CAUSE_INSTR_ACCESS_FAULT;
    mtval_o     = '0;
    if (fetch_err) begin
      exc_cause_o = EXC_CAUSE_INSTR_ACCESS_FAULT;
      // second half of an unaligned fetch faulted
      mtval_o     = instr_i.fetch_err_plus2 ? (instr_i.pc + 32'd2) : instr_i.pc;
    end else if (illegal_q) begin
      exc_cause_o = EXC_CAUSE_ILLEGAL_INSN;
      mtval_o     = instr_i.is_compressed ? {16'b0, instr_i.instr_c} : instr_i.instr;
    end else if (ecall) begin
      exc_cause_o = (priv_mode_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE :
                                                  EXC_CAUSE_ECALL_UMODE;
    end else if (ebrk) begin
      exc_cause_o = EXC_CAUSE_BREAKPOINT;
    end else if (store_err_q) begin
      exc_cause_o = EXC_CAUSE_STORE_ACCESS_FAULT;
      mtval_o     = lsu_addr_last_i;
    end else if (load_err_q) begin
      exc_cause_o = EXC_CAUSE_LOAD_ACCESS_FAULT;
      mtval_o     = lsu_addr_last_i;
    end
  end

endmodule

//--- verilog/irq_prio.sv
/*
  Interrupt decision for the controller.
  Ranks the pending lines, decides whether one is handled and tracks NMI mode.
*/

`timescale 1ns/1ps

module irq_prio
  import riscv_pkg::*;
#(
  parameter int unsigned NumFastIrq = 15
) (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  irqs_t      irqs_i,
  input  logic       irq_nm_i,
  input  logic       csr_mstatus_mie_i,

  input  logic       irq_take_i,
  input  logic       mret_done_i,

  output logic       handle_irq_o,
  output exc_cause_e irq_cause_o,
  output logic       nmi_mode_o
);

  logic     nmi_mode_d, nmi_mode_q;
  logic     irq_pending;
  logic     fast_any;
  fast_id_t fast_id;

  // only the implemented fast lines count
  assign irq_pending = irqs_i.irq_software | irqs_i.irq_timer | irqs_i.irq_external | fast_any;
  assign fast_any    = |irqs_i.irq_fast[NumFastIrq-1:0];

  // no nesting inside the NMI handler, not even a second NMI
  assign handle_irq_o = ~nmi_mode_q & (irq_nm_i | (irq_pending & csr_mstatus_mie_i));

  // highest fast index wins, later iterations override
  always_comb begin
    fast_id = '0;
    for (int unsigned i = 0; i < NumFastIrq; i++) begin
      if (irqs_i.irq_fast[i]) begin
        fast_id = fast_id_t'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // cause ranking
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    if (irq_nm_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_NM;
    end else if (fast_any) begin
      // interrupt flag plus 16 plus line index
      irq_cause_o = exc_cause_e'({2'b11, fast_id});
    end else if (irqs_i.irq_external) begin
      irq_cause_o = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irqs_i.irq_software) begin
      irq_cause_o = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else begin
      irq_cause_o = EXC_CAUSE_IRQ_TIMER_M;
    end
  end

  // enter on taking the NMI, leave on mret out of its handler
  always_comb begin
    nmi_mode_d = nmi_mode_q;
    if (irq_take_i && irq_nm_i) begin
      nmi_mode_d = 1'b1;
    end else if (mret_done_i) begin
      nmi_mode_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nmi_mode_q <= 1'b0;
    end else begin
      nmi_mode_q <= nmi_mode_d;
    end
  end

  assign nmi_mode_o = nmi_mode_q;

endmodule

//--- verilog/ctrl_fsm.sv
/*
  Main controller state machine.
  Sequences boot, traps, mret and sleep, and drives pc set, CSR save and stall signals.
*/

`timescale 1ns/1ps

module ctrl_fsm
  import riscv_pkg::*;
  import ctrl_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  // from the decision blocks
  input  flush_req_t req_i,
  input  exc_cause_e exc_cause_i,
  input  word_t      mtval_i,
  input  logic       handle_irq_i,
  input  exc_cause_e irq_cause_i,
  input  logic       nmi_mode_i,

  // pipeline status
  input  logic       instr_valid_i,
  input  logic       irq_pending_i,
  input  logic       stall_id_i,
  input  logic       branch_set_i,
  input  logic       jump_set_i,

  // strobes back to the decision blocks
  output logic       in_flush_o,
  output logic       irq_take_o,
  output logic       mret_done_o,

  // to prefetcher and CSRs
  output logic       pc_set_o,
  output pc_sel_e    pc_mux_o,
  output exc_cause_e exc_cause_o,
  output word_t      csr_mtval_o,
  output logic       csr_save_id_o,
  output logic       csr_save_if_o,
  output logic       csr_save_cause_o,
  output logic       csr_restore_mret_o,

  // to IF-ID
  output logic       instr_req_o,
  output logic       id_in_ready_o,
  output logic       instr_valid_clear_o,
  output logic       ctrl_busy_o,
  output logic       controller_run_o
);

  ctrl_state_e state_q, state_d;

  logic halt_if;
  logic retain_id;
  logic flush_id;

  always_comb begin
    state_d            = state_q;
    instr_req_o        = 1'b1;
    pc_set_o           = 1'b0;
    pc_mux_o           = PC_BOOT;
    // cause only matters with pc_set, default to the exception one
    exc_cause_o        = exc_cause_i;
    csr_mtval_o        = '0;
    csr_save_id_o      = 1'b0;
    csr_save_if_o      = 1'b0;
    csr_save_cause_o   = 1'b0;
    csr_restore_mret_o = 1'b0;
    irq_take_o         = 1'b0;
    mret_done_o        = 1'b0;
    ctrl_busy_o        = 1'b1;
    controller_run_o   = 1'b0;
    halt_if            = 1'b0;
    retain_id          = 1'b0;
    flush_id           = 1'b0;

    unique case (state_q)
      RESET: begin
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        state_d     = BOOT_SET;
      end

      BOOT_SET: begin
        // second strobe copies the boot address into the fetch pc
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end

      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = SLEEP;
      end

      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        // any pending line wakes the core, even with mie clear
        if (irq_pending_i || handle_irq_i) begin
          state_d = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end

      FIRST_FETCH: begin
        if (id_in_ready_o) begin
          state_d = DECODE;
        end
        // nothing in ID yet, so the interrupt can go straight away
        if (handle_irq_i) begin
          halt_if = 1'b1;
          state_d = IRQ_TAKEN;
        end
      end

      DECODE: begin
        controller_run_o = 1'b1;
        // jump target selected early, pc_set decides
        pc_mux_o         = PC_JUMP;

        // keep the instruction in ID so FLUSH can look at it
        if (req_i.special) begin
          retain_id = 1'b1;
          state_d   = FLUSH;
        end

        if (branch_set_i || jump_set_i) begin
          pc_set_o = 1'b1;
        end

        // hold off fetch until the current instruction is gone
        if (handle_irq_i && (stall_id_i || instr_valid_i)) begin
          halt_if = 1'b1;
        end

        if (!stall_id_i && !req_i.special && !instr_valid_i && handle_irq_i) begin
          halt_if = 1'b1;
          state_d = IRQ_TAKEN;
        end
      end

      IRQ_TAKEN: begin
        pc_mux_o    = PC_EXC;
        exc_cause_o = irq_cause_i;
        // line may have dropped meanwhile, then just resume
        if (handle_irq_i) begin
          pc_set_o         = 1'b1;
          csr_save_if_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          irq_take_o       = 1'b1;
        end
        state_d = DECODE;
      end

      FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = DECODE;

        if (req_i.exc_pending) begin
          // trap entry, epc comes from the instruction in ID
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXC;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          csr_mtval_o      = mtval_i;
        end else if (req_i.mret) begin
          pc_set_o           = 1'b1;
          pc_mux_o           = PC_ERET;
          csr_restore_mret_o = 1'b1;
          // returning from the NMI handler ends NMI mode
          mret_done_o        = nmi_mode_i;
        end else if (req_i.wfi) begin
          state_d = WAIT_SLEEP;
        end else if (req_i.csr_flush && handle_irq_i) begin
          // csr write may have just enabled an interrupt
          state_d = IRQ_TAKEN;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  assign in_flush_o = (state_q == FLUSH);

  ////////////////////////////////////////////////////////////////////
  // stall control
  ////////////////////////////////////////////////////////////////////

  assign id_in_ready_o = ~stall_id_i & ~halt_if & ~retain_id;

  // retain keeps instr_valid set unless ID is flushed as well
  assign instr_valid_clear_o = ~(stall_id_i | retain_id) | flush_id;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- verilog/ctrl_top.sv
/*
  Controller top level.
  Connects exception select, interrupt select and the main FSM.
*/

`timescale 1ns/1ps

module ctrl_top
  import riscv_pkg::*;
  import ctrl_pkg::*;
#(
  parameter int unsigned NumFastIrq = 15
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  input  logic        instr_valid_i,
  input  dec_flags_t  dec_i,
  input  instr_info_t instr_i,
  input  priv_lvl_e   priv_mode_i,
  input  logic        csr_mstatus_tw_i,
  input  logic        csr_mstatus_mie_i,
  input  irqs_t       irqs_i,
  input  logic        irq_nm_i,
  input  logic        load_err_i,
  input  logic        store_err_i,
  input  word_t       lsu_addr_last_i,
  input  logic        stall_id_i,
  input  logic        branch_set_i,
  input  logic        jump_set_i,

  output logic        pc_set_o,
  output pc_sel_e     pc_mux_o,
  output exc_cause_e  exc_cause_o,
  output word_t       csr_mtval_o,
  output logic        csr_save_id_o,
  output logic        csr_save_if_o,
  output logic        csr_save_cause_o,
  output logic        csr_restore_mret_o,
  output logic        instr_req_o,
  output logic        id_in_ready_o,
  output logic        instr_valid_clear_o,
  output logic        ctrl_busy_o,
  output logic        controller_run_o,
  output logic        nmi_mode_o
);

  flush_req_t flush_req;
  exc_cause_e exc_cause;
  word_t      exc_mtval;
  logic       handle_irq;
  exc_cause_e irq_cause;
  logic       irq_pending;
  logic       in_flush;
  logic       irq_take;
  logic       mret_done;

  // wake-up from sleep ignores mie
  assign irq_pending = |irqs_i;

  exc_prio i_exc_prio (
    .clk_i,
    .rst_ni,
    .instr_valid_i,
    .dec_i,
    .instr_i,
    .priv_mode_i,
    .csr_mstatus_tw_i,
    .load_err_i,
    .store_err_i,
    .lsu_addr_last_i,
    .in_flush_i  (in_flush),
    .req_o       (flush_req),
    .exc_cause_o (exc_cause),
    .mtval_o     (exc_mtval)
  );

  irq_prio #(
    .NumFastIrq (NumFastIrq)
  ) i_irq_prio (
    .clk_i,
    .rst_ni,
    .irqs_i,
    .irq_nm_i,
    .csr_mstatus_mie_i,
    .irq_take_i   (irq_take),
    .mret_done_i  (mret_done),
    .handle_irq_o (handle_irq),
    .irq_cause_o  (irq_cause),
    .nmi_mode_o
  );

  ctrl_fsm i_ctrl_fsm (
    .clk_i,
    .rst_ni,
    .req_i         (flush_req),
    .exc_cause_i   (exc_cause),
    .mtval_i       (exc_mtval),
    .handle_irq_i  (handle_irq),
    .irq_cause_i   (irq_cause),
    .nmi_mode_i    (nmi_mode_o),
    .instr_valid_i,
    .irq_pending_i (irq_pending),
    .stall_id_i,
    .branch_set_i,
    .jump_set_i,
    .in_flush_o    (in_flush),
    .irq_take_o    (irq_take),
    .mret_done_o   (mret_done),
    .pc_set_o,
    .pc_mux_o,
    .exc_cause_o,
    .csr_mtval_o,
    .csr_save_id_o,
    .csr_save_if_o,
    .csr_save_cause_o,
    .csr_restore_mret_o,
    .instr_req_o,
    .id_in_ready_o,
    .instr_valid_clear_o,
    .ctrl_busy_o,
    .controller_run_o
  );

endmodule

//--- bench/ctrl_tb_cases.svh
/*
  Stimulus and expectation table for the controller testbench.
  One row per scenario, walked in order by the driver loop.
*/

`ifndef CTRL_TB_CASES_SVH
`define CTRL_TB_CASES_SVH

// source of the expected mtval, data itself is random per row
typedef enum logic [2:0] {
  MT_ZERO,
  MT_PC,
  MT_PC2,
  MT_INSTR,
  MT_INSTR_C,
  MT_LSU
} mtval_src_e;

typedef struct packed {
  dec_flags_t dec;
  logic [3:0] info;
  logic [2:0] mode;
  irqs_t      irqs;
  logic [2:0] side;
  logic       strobe;
  pc_sel_e    pc_mux;
  logic [5:0] cause;
  mtval_src_e mtval_src;
  logic       nmi_mode;
} case_row_t;

case_row_t cases[$];

function automatic void add_case(input dec_flags_t dec, input logic [3:0] info,
                                 input logic [2:0] mode, input irqs_t irqs,
                                 input logic [2:0] side, input logic strobe,
                                 input pc_sel_e pc_mux, input logic [5:0] cause,
                                 input mtval_src_e mtval_src, input logic nmi_mode);
  cases.push_back('{dec, info, mode, irqs, side, strobe, pc_mux, cause, mtval_src, nmi_mode});
endfunction

// dec  {illegal, ecall, mret, wfi, ebrk, csr_flush}
// info {valid, fetch_err, plus2, compressed}, mode {umode, tw, mie}
// irqs {software, timer, external, fast[14:0]}, side {nmi, load_err, store_err}
// then expected: strobe, pc_mux, cause, mtval source, nmi_mode afterwards
function automatic void load_cases();
  // single exceptions
  add_case(6'h00, 4'hC, 3'h0, 18'h00000, 3'h0, 1'b1, PC_EXC, 6'h01, MT_PC, 1'b0);
  add_case(6'h00, 4'hE, 3'h0, 18'h00000, 3'h0, 1'b1, PC_EXC, 6'h01, MT_PC2, 1'b0);
  add_case(6'h20, 4'h8, 3'h0, 18'h00000, 3'h0, 1'b1, PC_EXC, 6'h02, MT_INSTR, 1'b0);
  add_case(6'h20, 4'h9, 3'h0, 18'h00000, 3'h0, 1'b1, PC_EXC, 6'h02, MT_INSTR_C, 1'b0);
  add_case(6'h10, 4'h8, 3'h0, 18'h00000, 3'h0, 1'b1, PC_EXC, 6'h0B, MT_ZERO, 1'b0);
  add_case(6'h10, 4'h8, 3'h4, 18'h00000, 3'h0, 1'b1, PC_EXC, 6'h08, MT_ZERO, 1'b0);
  add_case(6'h02, 4'h8, 3'h0, 18'h00000, 3'h0, 1'b1, PC_EXC, 6'h03, MT_ZERO, 1'b0);
  // mret and trapped wfi outside M-mode are illegal
  add_case(6'h08, 4'h8, 3'h4, 18'h00000, 3'h0, 1'b1, PC_EXC, 6'h02, MT_INSTR, 1'b0);
  add_case(6'h04, 4'h8, 3'h6, 18'h00000, 3'h0, 1'b1, PC_EXC, 6'h02, MT_INSTR, 1'b0);
  // several at once, fetch > illegal > ecall > ebreak > store > load
  add_case(6'h30, 4'hC, 3'h0, 18'h00000, 3'h0, 1'b1, PC_EXC, 6'h01, MT_PC, 1'b0);
  add_case(6'h32, 4'h8, 3'h0, 18'h00000, 3'h0, 1'b1, PC_EXC, 6'h02, MT_INSTR, 1'b0);
  add_case(6'h12, 4'h8, 3'h4, 18'h00000, 3'h0, 1'b1, PC_EXC, 6'h08, MT_ZERO, 1'b0);
  add_case(6'h02, 4'h8, 3'h0, 18'h00000, 3'h1, 1'b1, PC_EXC, 6'h03, MT_ZERO, 1'b0);
  add_case(6'h18, 4'h8, 3'h4, 18'h00000, 3'h0, 1'b1, PC_EXC, 6'h02, MT_INSTR, 1'b0);
  // lsu faults with ID empty
  add_case(6'h00, 4'h0, 3'h0, 18'h00000, 3'h2, 1'b1, PC_EXC, 6'h05, MT_LSU, 1'b0);
  add_case(6'h00, 4'h0, 3'h0, 18'h00000, 3'h1, 1'b1, PC_EXC, 6'h07, MT_LSU, 1'b0);
  add_case(6'h00, 4'h0, 3'h0, 18'h00000, 3'h3, 1'b1, PC_EXC, 6'h07, MT_LSU, 1'b0);
  // interrupt rank, NMI > fast (highest) > external > software > timer
  add_case(6'h00, 4'h0, 3'h1, 18'h10000, 3'h0, 1'b1, PC_EXC, 6'h27, MT_ZERO, 1'b0);
  add_case(6'h00, 4'h0, 3'h1, 18'h30000, 3'h0, 1'b1, PC_EXC, 6'h23, MT_ZERO, 1'b0);
  add_case(6'h00, 4'h0, 3'h1, 18'h28000, 3'h0, 1'b1, PC_EXC, 6'h2B, MT_ZERO, 1'b0);
  add_case(6'h00, 4'h0, 3'h1, 18'h08001, 3'h0, 1'b1, PC_EXC, 6'h30, MT_ZERO, 1'b0);
  add_case(6'h00, 4'h0, 3'h1, 18'h10208, 3'h0, 1'b1, PC_EXC, 6'h39, MT_ZERO, 1'b0);
  add_case(6'h00, 4'h0, 3'h1, 18'h04000, 3'h0, 1'b1, PC_EXC, 6'h3E, MT_ZERO, 1'b0);
  // global enable off
  add_case(6'h00, 4'h0, 3'h0, 18'h08000, 3'h0, 1'b0, PC_BOOT, 6'h00, MT_ZERO, 1'b0);
  // nmi ignores mie, then nothing nests until mret
  add_case(6'h00, 4'h0, 3'h0, 18'h00004, 3'h4, 1'b1, PC_EXC, 6'h3F, MT_ZERO, 1'b1);
  add_case(6'h00, 4'h0, 3'h1, 18'h10000, 3'h0, 1'b0, PC_BOOT, 6'h00, MT_ZERO, 1'b1);
  add_case(6'h00, 4'h0, 3'h1, 18'h00000, 3'h4, 1'b0, PC_BOOT, 6'h00, MT_ZERO, 1'b1);
  add_case(6'h08, 4'h8, 3'h0, 18'h00000, 3'h0, 1'b1, PC_ERET, 6'h00, MT_ZERO, 1'b0);
  add_case(6'h00, 4'h0, 3'h1, 18'h10000, 3'h0, 1'b1, PC_EXC, 6'h27, MT_ZERO, 1'b0);
endfunction

`endif

//--- bench/ctrl_tb.sv
/*
  Testbench for the controller top level.
  Checks boot, the trap table from ctrl_tb_cases.svh and WFI sleep and wake-up.
*/

`timescale 1ns/1ps

module ctrl_tb
  import riscv_pkg::*;
  import ctrl_pkg::*;
();

  localparam int DriveDelay    = 1;
  localparam int TimeoutCycles = 20;
  localparam int QuietCycles   = 10;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  dec_flags_t  dec;
  instr_info_t instr;
  priv_lvl_e   priv_mode;
  logic        csr_tw;
  logic        csr_mie;
  irqs_t       irqs;
  logic        irq_nm;
  logic        load_err;
  logic        store_err;
  word_t       lsu_addr;
  logic        stall_id;
  logic        branch_set;
  logic        jump_set;

  logic        pc_set_o;
  pc_sel_e     pc_mux_o;
  exc_cause_e  exc_cause_o;
  word_t       csr_mtval_o;
  logic        csr_save_id_o;
  logic        csr_save_if_o;
  logic        csr_save_cause_o;
  logic        csr_restore_mret_o;
  logic        instr_req_o;
  logic        id_in_ready_o;
  logic        instr_valid_clear_o;
  logic        ctrl_busy_o;
  logic        controller_run_o;
  logic        nmi_mode_o;

  int          seed;

  `include "ctrl_tb_cases.svh"

  ctrl_top #(
    .NumFastIrq (15)
  ) i_dut (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .instr_valid_i       (instr_valid),
    .dec_i               (dec),
    .instr_i             (instr),
    .priv_mode_i         (priv_mode),
    .csr_mstatus_tw_i    (csr_tw),
    .csr_mstatus_mie_i   (csr_mie),
    .irqs_i              (irqs),
    .irq_nm_i            (irq_nm),
    .load_err_i          (load_err),
    .store_err_i         (store_err),
    .lsu_addr_last_i     (lsu_addr),
    .stall_id_i          (stall_id),
    .branch_set_i        (branch_set),
    .jump_set_i          (jump_set),
    .pc_set_o,
    .pc_mux_o,
    .exc_cause_o,
    .csr_mtval_o,
    .csr_save_id_o,
    .csr_save_if_o,
    .csr_save_cause_o,
    .csr_restore_mret_o,
    .instr_req_o,
    .id_in_ready_o,
    .instr_valid_clear_o,
    .ctrl_busy_o,
    .controller_run_o,
    .nmi_mode_o
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // failure and compare
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout after %0d cycles: %s", TimeoutCycles, what);
    abort_run();
  endtask

  //////////////////////////////////////////////////////////////////////
  // waits, sampled at the falling edge where outputs are settled
  //////////////////////////////////////////////////////////////////////

  // lat counts the cycles between the drive cycle and the strobe
  task automatic wait_strobe(output int lat);
    lat = 0;
    @(negedge clk);
    while (!pc_set_o && lat <= TimeoutCycles) begin
      lat++;
      @(negedge clk);
    end
    if (!pc_set_o) begin
      report_timeout("pc_set_o never strobed");
    end
  endtask

  task automatic wait_busy(input logic level);
    int n;
    n = 0;
    @(negedge clk);
    while (ctrl_busy_o !== level && n < TimeoutCycles) begin
      n++;
      @(negedge clk);
    end
    if (ctrl_busy_o !== level) begin
      report_timeout("ctrl_busy_o did not reach the expected level");
    end
  endtask

  // idle pipeline, M-mode, nothing pending
  task automatic clear_inputs();
    instr_valid = 1'b0;
    dec         = '0;
    instr       = '0;
    priv_mode   = PRIV_LVL_M;
    csr_tw      = 1'b0;
    csr_mie     = 1'b0;
    irqs        = '0;
    irq_nm      = 1'b0;
    load_err    = 1'b0;
    store_err   = 1'b0;
    lsu_addr    = '0;
    stall_id    = 1'b0;
    branch_set  = 1'b0;
    jump_set    = 1'b0;
  endtask

  function automatic word_t expected_mtval(input mtval_src_e src, input word_t iw,
                                           input word_t half, input word_t pc,
                                           input word_t lsu);
    case (src)
      MT_PC:      return pc;
      MT_PC2:     return pc + 32'd2;
      MT_INSTR:   return iw;
      MT_INSTR_C: return {16'h0000, half[15:0]};
      MT_LSU:     return lsu;
      default:    return '0;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // scenarios
  //////////////////////////////////////////////////////////////////////

  // two boot strobes, then FIRST_FETCH and DECODE
  task automatic check_boot();
    repeat (2) @(posedge clk);
    #(DriveDelay);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("boot0 pc_set", 32'(pc_set_o), 32'd1);
    check_value("boot0 pc_mux", 32'(pc_mux_o), 32'(PC_BOOT));
    check_value("boot0 instr_req", 32'(instr_req_o), 32'd0);
    check_value("boot0 nmi_mode", 32'(nmi_mode_o), 32'd0);
    check_value("boot0 run", 32'(controller_run_o), 32'd0);
    check_value("boot0 csr_save", 32'({csr_save_id_o, csr_save_if_o, csr_save_cause_o}),
                32'd0);
    @(negedge clk);
    check_value("boot1 pc_set", 32'(pc_set_o), 32'd1);
    check_value("boot1 pc_mux", 32'(pc_mux_o), 32'(PC_BOOT));
    @(negedge clk);
    check_value("first fetch pc_set", 32'(pc_set_o), 32'd0);
    check_value("first fetch id_ready", 32'(id_in_ready_o), 32'd1);
    @(negedge clk);
    check_value("decode run", 32'(controller_run_o), 32'd1);
  endtask

  task automatic apply_case(input int idx, input case_row_t row);
    word_t rnd_instr;
    word_t rnd_half;
    word_t rnd_pc;
    word_t rnd_lsu;
    string tag;
    int    lat;
    rnd_instr = $random(seed);
    rnd_half  = $random(seed);
    rnd_pc    = $random(seed);
    rnd_lsu   = $random(seed);
    tag       = $sformatf("case %0d", idx);
    @(posedge clk);
    #(DriveDelay);
    instr_valid           = row.info[3];
    dec                   = row.dec;
    instr.instr           = rnd_instr;
    instr.instr_c         = rnd_half[15:0];
    instr.is_compressed   = row.info[0];
    instr.fetch_err       = row.info[2];
    instr.fetch_err_plus2 = row.info[1];
    instr.pc              = rnd_pc;
    priv_mode             = row.mode[2] ? PRIV_LVL_U : PRIV_LVL_M;
    csr_tw                = row.mode[1];
    csr_mie               = row.mode[0];
    irqs                  = row.irqs;
    irq_nm                = row.side[2];
    load_err              = row.side[1];
    store_err             = row.side[0];
    lsu_addr              = rnd_lsu;
    if (row.strobe) begin
      wait_strobe(lat);
      // no stall, so every trap and interrupt lands one cycle later
      check_value({tag, " latency"}, 32'(lat), 32'd1);
      check_value({tag, " pc_mux"}, 32'(pc_mux_o), 32'(row.pc_mux));
      if (row.pc_mux == PC_EXC) begin
        check_value({tag, " cause"}, 32'(exc_cause_o), 32'(row.cause));
      end
      check_value({tag, " mtval"}, csr_mtval_o,
                  expected_mtval(row.mtval_src, rnd_instr, rnd_half, rnd_pc, rnd_lsu));
      // exceptions save epc from ID, interrupts from IF
      check_value({tag, " save_cause"}, 32'(csr_save_cause_o), 32'(row.pc_mux == PC_EXC));
      check_value({tag, " save_id"}, 32'(csr_save_id_o),
                  32'(row.pc_mux == PC_EXC && !row.cause[5]));
      check_value({tag, " save_if"}, 32'(csr_save_if_o),
                  32'(row.pc_mux == PC_EXC && row.cause[5]));
      check_value({tag, " restore_mret"}, 32'(csr_restore_mret_o),
                  32'(row.pc_mux == PC_ERET));
      check_value({tag, " valid_clear"}, 32'(instr_valid_clear_o), 32'd1);
    end else begin
      repeat (QuietCycles) begin
        @(negedge clk);
        check_value({tag, " quiet pc_set"}, 32'(pc_set_o), 32'd0);
        check_value({tag, " quiet save_cause"}, 32'(csr_save_cause_o), 32'd0);
      end
    end
    @(posedge clk);
    #(DriveDelay);
    clear_inputs();
    @(negedge clk);
    check_value({tag, " nmi_mode"}, 32'(nmi_mode_o), 32'(row.nmi_mode));
  endtask

  // wfi puts the core to sleep, a timer line wakes it and is taken
  task automatic run_wfi();
    int lat;
    @(posedge clk);
    #(DriveDelay);
    instr_valid = 1'b1;
    dec.wfi     = 1'b1;
    csr_mie     = 1'b1;
    wait_busy(1'b0);
    @(posedge clk);
    #(DriveDelay);
    instr_valid = 1'b0;
    dec         = '0;
    repeat (4) begin
      @(negedge clk);
      check_value("sleep busy", 32'(ctrl_busy_o), 32'd0);
      check_value("sleep instr_req", 32'(instr_req_o), 32'd0);
      check_value("sleep valid_clear", 32'(instr_valid_clear_o), 32'd1);
    end
    @(posedge clk);
    #(DriveDelay);
    irqs.irq_timer = 1'b1;
    wait_busy(1'b1);
    wait_strobe(lat);
    check_value("wake pc_mux", 32'(pc_mux_o), 32'(PC_EXC));
    check_value("wake cause", 32'(exc_cause_o), 32'h27);
    check_value("wake save_if", 32'(csr_save_if_o), 32'd1);
    check_value("wake save_cause", 32'(csr_save_cause_o), 32'd1);
    @(posedge clk);
    #(DriveDelay);
    clear_inputs();
    @(negedge clk);
    check_value("awake busy", 32'(ctrl_busy_o), 32'd1);
  endtask

  initial begin
    seed  = 32'h28e4_2b9e;
    rst_n = 1'b0;
    clear_inputs();
    load_cases();
    check_boot();
    for (int i = 0; i < cases.size(); i++) begin
      apply_case(i, cases[i]);
    end
    run_wfi();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- ctrl_top.f
+incdir+bench
verilog/riscv_pkg.sv
verilog/ctrl_pkg.sv
verilog/exc_prio.sv
verilog/irq_prio.sv
verilog/ctrl_fsm.sv
verilog/ctrl_top.sv
bench/ctrl_tb.sv

//--- Makefile
# Verilator build and run of the controller testbench

TB := ctrl_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f ctrl_top.f --top-module $(TB) -Mdir obj_dir
	./obj_dir/V$(TB)

clean:
	rm -rf obj_dir
